//--- logic/jfive_decode_macros.svh
`ifndef JFIVE_DECODE_MACROS_SVH
`define JFIVE_DECODE_MACROS_SVH

// hardware threads and thread id width
`define JFIVE_THREADS 4
`define JFIVE_ID_BITS 2

// execution-unit destination ports watched for hazards
`define JFIVE_EXES 4

// datapath widths
`define JFIVE_XLEN 32
`define JFIVE_PC_BITS 32

`endif

//--- logic/jfive_decode_pkg.sv
`include "jfive_decode_macros.svh"

package jfive_decode_pkg;

    // ----------------------------------------------------------------------
    // upper five opcode bits above the fixed low 11
    // ----------------------------------------------------------------------
    localparam logic [4:0] OPC_LUI    = 5'b01101;
    localparam logic [4:0] OPC_AUIPC  = 5'b00101;
    localparam logic [4:0] OPC_JAL    = 5'b11011;
    localparam logic [4:0] OPC_JALR   = 5'b11001;
    localparam logic [4:0] OPC_BRANCH = 5'b11000;
    localparam logic [4:0] OPC_LOAD   = 5'b00000;
    localparam logic [4:0] OPC_STORE  = 5'b01000;
    localparam logic [4:0] OPC_ALUI   = 5'b00100;
    localparam logic [4:0] OPC_ALU    = 5'b01100;

    // funct3 of the alu group
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SL   = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // ----------------------------------------------------------------------
    // types
    // ----------------------------------------------------------------------
    typedef logic [`JFIVE_ID_BITS-1:0] id_t;
    typedef logic [`JFIVE_PC_BITS-1:0] pc_t;
    typedef logic [4:0]                ridx_t;
    typedef logic [`JFIVE_XLEN-1:0]    rval_t;

    typedef struct packed {
        id_t         id;
        pc_t         pc;
        logic [31:0] instr;
    } instr_ctx_t;

    typedef struct packed {
        logic  en;
        id_t   id;
        ridx_t idx;
    } reg_write_t;

    typedef struct packed {
        reg_write_t wr;
        rval_t      val;
    } wb_write_t;

    typedef struct packed {
        logic lui;
        logic auipc;
        logic jal;
        logic jalr;
        logic branch;
        logic load;
        logic store;
        logic alu;
        logic alui;
        logic rd_en;
        logic rs1_en;
        logic rs2_en;
    } class_t;

    typedef struct packed {
        logic       offset;
        logic       adder;
        logic       logical;
        logic       shifter;
        logic       load;
        logic       store;
        logic       branch;
        logic       adder_sub;
        logic       adder_imm_en;
        rval_t      adder_imm_val;
        logic [1:0] logical_mode;
        logic       shifter_arithmetic;
        logic       shifter_left;
        logic       shifter_imm_en;
        logic [4:0] shifter_imm_val;
        logic [2:0] branch_mode;
        pc_t        branch_pc;
    } decode_ctrl_t;

endpackage

//--- logic/reg_file.sv
`timescale 1ns/10ps
`include "jfive_decode_macros.svh"

module reg_file (
    input  logic                              clk,
    input  jfive_decode_pkg::wb_write_t       wb,
    input  logic [`JFIVE_ID_BITS+4:0]         rd_addr1,
    input  logic [`JFIVE_ID_BITS+4:0]         rd_addr2,
    output jfive_decode_pkg::rval_t           rd_data1,
    output jfive_decode_pkg::rval_t           rd_data2
);

    // thread id in the upper address bits
    localparam int WORDS = `JFIVE_THREADS * 32;

    jfive_decode_pkg::rval_t     mem [WORDS];
    logic [`JFIVE_ID_BITS+4:0]   wr_addr;

    assign wr_addr = {wb.wr.id, wb.wr.idx};

    always_ff @(posedge clk) begin
        if (wb.wr.en) begin
            mem[wr_addr] <= wb.val;
        end
    end

    // same-edge write shows on the read data
    always_ff @(posedge clk) begin
        rd_data1 <= (wb.wr.en && wr_addr == rd_addr1) ? wb.val : mem[rd_addr1];
        rd_data2 <= (wb.wr.en && wr_addr == rd_addr2) ? wb.val : mem[rd_addr2];
    end

endmodule

//--- logic/hazard_check.sv
`timescale 1ns/10ps

module hazard_check #(
    parameter int NUM_WRITERS = 1
) (
    input  jfive_decode_pkg::id_t                          id,
    input  logic                                           rs1_en,
    input  logic                                           rs2_en,
    input  jfive_decode_pkg::ridx_t                        rs1_idx,
    input  jfive_decode_pkg::ridx_t                        rs2_idx,
    input  jfive_decode_pkg::reg_write_t [NUM_WRITERS-1:0] writers,
    output logic                                           hit
);

    // raw against any pending writer of the same thread
    always_comb begin
        hit = 1'b0;
        for (int i = 0; i < NUM_WRITERS; i++) begin
            if (writers[i].en && writers[i].id == id) begin
                if (rs1_en && writers[i].idx == rs1_idx) begin
                    hit = 1'b1;
                end
                if (rs2_en && writers[i].idx == rs2_idx) begin
                    hit = 1'b1;
                end
            end
        end
    end

endmodule

//--- logic/instr_classify.sv
`timescale 1ns/10ps

module instr_classify (
    input  logic                         clk,
    input  logic                         reset,
    input  jfive_decode_pkg::instr_ctx_t s_ctx,
    input  logic                         s_valid,
    input  logic                         hold,
    output jfive_decode_pkg::instr_ctx_t ctx0,
    output jfive_decode_pkg::class_t     class0,
    output logic                         valid0
);

    logic [4:0]               opc;
    jfive_decode_pkg::class_t cls;

    assign opc = s_ctx.instr[6:2];

    always_comb begin
        cls.lui    = opc == jfive_decode_pkg::OPC_LUI;
        cls.auipc  = opc == jfive_decode_pkg::OPC_AUIPC;
        cls.jal    = opc == jfive_decode_pkg::OPC_JAL;
        cls.jalr   = opc == jfive_decode_pkg::OPC_JALR;
        cls.branch = opc == jfive_decode_pkg::OPC_BRANCH;
        cls.load   = opc == jfive_decode_pkg::OPC_LOAD;
        cls.store  = opc == jfive_decode_pkg::OPC_STORE;
        cls.alu    = opc == jfive_decode_pkg::OPC_ALU;
        cls.alui   = opc == jfive_decode_pkg::OPC_ALUI;

        // x0 never counts as a source or a destination
        cls.rd_en  = s_valid && s_ctx.instr[11:7] != 5'd0
                     && (cls.lui || cls.auipc || cls.jal || cls.jalr
                         || cls.load || cls.alui || cls.alu);
        cls.rs1_en = s_valid && s_ctx.instr[19:15] != 5'd0
                     && (cls.jalr || cls.branch || cls.load || cls.store
                         || cls.alui || cls.alu);
        cls.rs2_en = s_valid && s_ctx.instr[24:20] != 5'd0
                     && (cls.branch || cls.store || cls.alu);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid0 <= 1'b0;
        end else if (!hold) begin
            valid0 <= s_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            ctx0   <= s_ctx;
            class0 <= cls;
        end
    end

endmodule

//--- logic/pipe_control.sv
`timescale 1ns/10ps

module pipe_control (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 m_wait,
    input  jfive_decode_pkg::instr_ctx_t         ctx0,
    input  jfive_decode_pkg::class_t             class0,
    input  logic                                 valid0,
    input  logic                                 pre_hit,
    input  logic                                 rel_hit,
    output jfive_decode_pkg::instr_ctx_t         ctx1,
    output jfive_decode_pkg::class_t             class1,
    output jfive_decode_pkg::instr_ctx_t         ctx2,
    output jfive_decode_pkg::class_t             class2,
    output logic                                 valid2,
    output logic                                 stall2,
    output jfive_decode_pkg::reg_write_t [1:0]   pipe_wr,
    output logic                                 s_wait
);

    logic valid1;
    logic pre1;

    assign s_wait = stall2 || m_wait;

    // pre-stall rides with the instruction, then turns into stall2
    always_ff @(posedge clk) begin
        if (reset) begin
            valid1 <= 1'b0;
            valid2 <= 1'b0;
            pre1   <= 1'b0;
            stall2 <= 1'b0;
        end else if (!s_wait) begin
            valid1 <= valid0;
            valid2 <= valid1;
            pre1   <= valid0 && pre_hit;
            stall2 <= valid1 && pre1;
        end else if (stall2) begin
            stall2 <= rel_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (!s_wait) begin
            ctx1   <= ctx0;
            class1 <= class0;
            ctx2   <= ctx1;
            class2 <= class1;
        end
    end

    // older in-pipe destinations
    assign pipe_wr[0] = '{en: valid1 && class1.rd_en, id: ctx1.id, idx: ctx1.instr[11:7]};
    assign pipe_wr[1] = '{en: valid2 && class2.rd_en, id: ctx2.id, idx: ctx2.instr[11:7]};

endmodule

//--- logic/operand_fetch.sv
`timescale 1ns/10ps
`include "jfive_decode_macros.svh"

module operand_fetch (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         hold,
    input  jfive_decode_pkg::wb_write_t  wb,
    input  jfive_decode_pkg::instr_ctx_t ctx0,
    input  jfive_decode_pkg::instr_ctx_t ctx1,
    input  jfive_decode_pkg::class_t     class1,
    input  jfive_decode_pkg::instr_ctx_t ctx2,
    output logic                         rs1_en,
    output logic                         rs2_en,
    output jfive_decode_pkg::rval_t      rs1_val,
    output jfive_decode_pkg::rval_t      rs2_val
);

    logic [`JFIVE_ID_BITS+4:0] rd_addr1;
    logic [`JFIVE_ID_BITS+4:0] rd_addr2;
    logic [`JFIVE_ID_BITS+4:0] wb_addr;
    jfive_decode_pkg::rval_t   rd_data1;
    jfive_decode_pkg::rval_t   rd_data2;

    // while held, re-read the stage-1 sources to keep them current
    assign rd_addr1 = hold ? {ctx1.id, ctx1.instr[19:15]} : {ctx0.id, ctx0.instr[19:15]};
    assign rd_addr2 = hold ? {ctx1.id, ctx1.instr[24:20]} : {ctx0.id, ctx0.instr[24:20]};
    assign wb_addr  = {wb.wr.id, wb.wr.idx};

    reg_file u_reg_file (
        .clk      (clk),
        .wb       (wb),
        .rd_addr1 (rd_addr1),
        .rd_addr2 (rd_addr2),
        .rd_data1 (rd_data1),
        .rd_data2 (rd_data2)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            rs1_en <= 1'b0;
            rs2_en <= 1'b0;
        end else if (!hold) begin
            rs1_en <= class1.rs1_en;
            rs2_en <= class1.rs2_en;
        end
    end

    // writeback forwarding on load and while held
    always_ff @(posedge clk) begin
        if (!hold) begin
            rs1_val <= (wb.wr.en && wb_addr == {ctx1.id, ctx1.instr[19:15]}) ? wb.val : rd_data1;
            rs2_val <= (wb.wr.en && wb_addr == {ctx1.id, ctx1.instr[24:20]}) ? wb.val : rd_data2;
        end else begin
            if (wb.wr.en && wb_addr == {ctx2.id, ctx2.instr[19:15]}) begin
                rs1_val <= wb.val;
            end
            if (wb.wr.en && wb_addr == {ctx2.id, ctx2.instr[24:20]}) begin
                rs2_val <= wb.val;
            end
        end
    end

endmodule

//--- logic/control_decode.sv
`timescale 1ns/10ps

module control_decode (
    input  logic                           clk,
    input  logic                           hold,
    input  jfive_decode_pkg::instr_ctx_t   ctx1,
    input  jfive_decode_pkg::class_t       class1,
    output jfive_decode_pkg::decode_ctrl_t ctrl,
    output jfive_decode_pkg::rval_t        rd_val
);

    logic [2:0]         funct3;
    logic               arith;
    logic signed [11:0] imm_i;
    logic signed [12:0] imm_b;
    logic signed [20:0] imm_j;
    logic [31:0]        imm_u;

    // ----------------------------------------------------------------------
    // instruction fields
    // ----------------------------------------------------------------------
    assign funct3 = ctx1.instr[14:12];
    assign arith  = class1.alu || class1.alui;
    assign imm_i  = ctx1.instr[31:20];
    assign imm_b  = {ctx1.instr[31], ctx1.instr[7], ctx1.instr[30:25], ctx1.instr[11:8], 1'b0};
    assign imm_j  = {ctx1.instr[31], ctx1.instr[19:12], ctx1.instr[20], ctx1.instr[30:21], 1'b0};
    assign imm_u  = {ctx1.instr[31:12], 12'd0};

    // ----------------------------------------------------------------------
    // stage-2 control bundle
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!hold) begin
            ctrl.offset  <= class1.lui || class1.auipc || class1.jal || class1.jalr;
            ctrl.adder   <= arith && (funct3 == jfive_decode_pkg::F3_ADD
                                      || funct3 == jfive_decode_pkg::F3_SLT
                                      || funct3 == jfive_decode_pkg::F3_SLTU);
            ctrl.logical <= arith && (funct3 == jfive_decode_pkg::F3_XOR
                                      || funct3 == jfive_decode_pkg::F3_OR
                                      || funct3 == jfive_decode_pkg::F3_AND);
            ctrl.shifter <= arith && (funct3 == jfive_decode_pkg::F3_SL
                                      || funct3 == jfive_decode_pkg::F3_SR);
            ctrl.load    <= class1.load;
            ctrl.store   <= class1.store;
            ctrl.branch  <= class1.jal || class1.jalr || class1.branch;

            // compare for branches goes through the subtractor
            ctrl.adder_sub     <= (class1.alu && funct3 == jfive_decode_pkg::F3_ADD
                                   && ctx1.instr[30]) || class1.branch;
            ctrl.adder_imm_en  <= class1.jalr || class1.alui;
            ctrl.adder_imm_val <= (funct3 == jfive_decode_pkg::F3_SLTU)
                                  ? jfive_decode_pkg::rval_t'($unsigned(imm_i))
                                  : jfive_decode_pkg::rval_t'(imm_i);

            ctrl.logical_mode <= funct3[1:0];

            ctrl.shifter_arithmetic <= ctx1.instr[30];
            ctrl.shifter_left       <= ~funct3[2];
            ctrl.shifter_imm_en     <= class1.alui;
            ctrl.shifter_imm_val    <= ctx1.instr[24:20];

            // jal and jalr get their own modes
            ctrl.branch_mode <= class1.jal ? 3'd2 : (class1.jalr ? 3'd3 : funct3);
            ctrl.branch_pc   <= ctx1.pc + (class1.jal ? jfive_decode_pkg::pc_t'(imm_j)
                                                      : jfive_decode_pkg::pc_t'(imm_b));

            // link or upper immediate
            if (class1.lui) begin
                rd_val <= jfive_decode_pkg::rval_t'(imm_u);
            end else if (class1.auipc) begin
                rd_val <= jfive_decode_pkg::rval_t'(ctx1.pc) + jfive_decode_pkg::rval_t'(imm_u);
            end else begin
                rd_val <= jfive_decode_pkg::rval_t'(ctx1.pc) + jfive_decode_pkg::rval_t'(4);
            end
        end
    end

endmodule

//--- logic/jfive_decode.sv
`timescale 1ns/10ps
`include "jfive_decode_macros.svh"

module jfive_decode (
    input  logic                                         clk,
    input  logic                                         reset,
    input  jfive_decode_pkg::instr_ctx_t                 s_ctx,
    input  logic                                         s_valid,
    output logic                                         s_wait,
    input  jfive_decode_pkg::reg_write_t [`JFIVE_EXES-1:0] exe_wr,
    input  jfive_decode_pkg::wb_write_t                  wb,
    output jfive_decode_pkg::instr_ctx_t                 m_ctx,
    output jfive_decode_pkg::reg_write_t                 m_rd,
    output logic                                         m_rs1_en,
    output jfive_decode_pkg::rval_t                      m_rs1_val,
    output logic                                         m_rs2_en,
    output jfive_decode_pkg::rval_t                      m_rs2_val,
    output jfive_decode_pkg::rval_t                      m_rd_val,
    output jfive_decode_pkg::decode_ctrl_t               m_ctrl,
    output logic                                         m_valid,
    input  logic                                         m_wait
);

    jfive_decode_pkg::instr_ctx_t      ctx0;
    jfive_decode_pkg::class_t          class0;
    logic                              valid0;
    jfive_decode_pkg::instr_ctx_t      ctx1;
    jfive_decode_pkg::class_t          class1;
    jfive_decode_pkg::instr_ctx_t      ctx2;
    jfive_decode_pkg::class_t          class2;
    logic                              valid2;
    logic                              stall2;
    jfive_decode_pkg::reg_write_t [1:0] pipe_wr;
    logic                              pre_hit;
    logic                              rel_hit;

    // ----------------------------------------------------------------------
    // stage 0 and hazard checks
    // ----------------------------------------------------------------------
    instr_classify u_instr_classify (
        .clk     (clk),
        .reset   (reset),
        .s_ctx   (s_ctx),
        .s_valid (s_valid),
        .hold    (s_wait),
        .ctx0    (ctx0),
        .class0  (class0),
        .valid0  (valid0)
    );

    // against the exe ports and the two older stages
    hazard_check #(.NUM_WRITERS(`JFIVE_EXES + 2)) u_pre_check (
        .id      (ctx0.id),
        .rs1_en  (class0.rs1_en),
        .rs2_en  (class0.rs2_en),
        .rs1_idx (ctx0.instr[19:15]),
        .rs2_idx (ctx0.instr[24:20]),
        .writers ({pipe_wr, exe_wr}),
        .hit     (pre_hit)
    );

    // release of a stalled stage-2 instruction
    hazard_check #(.NUM_WRITERS(`JFIVE_EXES)) u_rel_check (
        .id      (ctx2.id),
        .rs1_en  (class2.rs1_en),
        .rs2_en  (class2.rs2_en),
        .rs1_idx (ctx2.instr[19:15]),
        .rs2_idx (ctx2.instr[24:20]),
        .writers (exe_wr),
        .hit     (rel_hit)
    );

    // ----------------------------------------------------------------------
    // stages 1 and 2
    // ----------------------------------------------------------------------
    pipe_control u_pipe_control (
        .clk     (clk),
        .reset   (reset),
        .m_wait  (m_wait),
        .ctx0    (ctx0),
        .class0  (class0),
        .valid0  (valid0),
        .pre_hit (pre_hit),
        .rel_hit (rel_hit),
        .ctx1    (ctx1),
        .class1  (class1),
        .ctx2    (ctx2),
        .class2  (class2),
        .valid2  (valid2),
        .stall2  (stall2),
        .pipe_wr (pipe_wr),
        .s_wait  (s_wait)
    );

    operand_fetch u_operand_fetch (
        .clk     (clk),
        .reset   (reset),
        .hold    (s_wait),
        .wb      (wb),
        .ctx0    (ctx0),
        .ctx1    (ctx1),
        .class1  (class1),
        .ctx2    (ctx2),
        .rs1_en  (m_rs1_en),
        .rs2_en  (m_rs2_en),
        .rs1_val (m_rs1_val),
        .rs2_val (m_rs2_val)
    );

    control_decode u_control_decode (
        .clk    (clk),
        .hold   (s_wait),
        .ctx1   (ctx1),
        .class1 (class1),
        .ctrl   (m_ctrl),
        .rd_val (m_rd_val)
    );

    assign m_ctx   = ctx2;
    assign m_rd    = '{en: class2.rd_en, id: ctx2.id, idx: ctx2.instr[11:7]};
    assign m_valid = valid2 && !stall2;

endmodule

//--- verification/decode_model.svh
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// expected outputs of one instruction
typedef struct packed {
    jfive_decode_pkg::instr_ctx_t   ctx;
    jfive_decode_pkg::reg_write_t   rd;
    logic                           rs1_en;
    jfive_decode_pkg::rval_t        rs1_val;
    logic                           rs2_en;
    jfive_decode_pkg::rval_t        rs2_val;
    jfive_decode_pkg::decode_ctrl_t ctrl;
    jfive_decode_pkg::rval_t        rd_val;
} expect_t;

// register contents per thread seen by the DUT
jfive_decode_pkg::rval_t regs [`JFIVE_THREADS][32];

function automatic expect_t build_expect(input jfive_decode_pkg::instr_ctx_t ctx);
    expect_t     e;
    logic [31:0] w;
    logic [4:0]  op;
    logic [2:0]  f3;
    logic        is_lui;
    logic        is_auipc;
    logic        is_jal;
    logic        is_jalr;
    logic        is_br;
    logic        is_ld;
    logic        is_st;
    logic        is_alu;
    logic        is_alui;
    logic [31:0] imm_i;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic [31:0] imm_u;
    w        = ctx.instr;
    op       = w[6:2];
    f3       = w[14:12];
    is_lui   = op == 5'b01101;
    is_auipc = op == 5'b00101;
    is_jal   = op == 5'b11011;
    is_jalr  = op == 5'b11001;
    is_br    = op == 5'b11000;
    is_ld    = op == 5'b00000;
    is_st    = op == 5'b01000;
    is_alui  = op == 5'b00100;
    is_alu   = op == 5'b01100;
    imm_i    = (f3 == 3'd3) ? {20'd0, w[31:20]} : {{20{w[31]}}, w[31:20]};
    imm_b    = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    imm_j    = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    imm_u    = {w[31:12], 12'd0};

    e.ctx    = ctx;
    e.rd.en  = (w[11:7] != 0) && (is_lui || is_auipc || is_jal || is_jalr || is_ld
                                  || is_alui || is_alu);
    e.rd.id  = ctx.id;
    e.rd.idx = w[11:7];
    e.rs1_en = (w[19:15] != 0) && (is_jalr || is_br || is_ld || is_st || is_alui || is_alu);
    e.rs2_en = (w[24:20] != 0) && (is_br || is_st || is_alu);
    e.rs1_val = regs[ctx.id][w[19:15]];
    e.rs2_val = regs[ctx.id][w[24:20]];

    e.ctrl.offset  = is_lui || is_auipc || is_jal || is_jalr;
    e.ctrl.adder   = (is_alu || is_alui) && (f3 == 3'd0 || f3 == 3'd2 || f3 == 3'd3);
    e.ctrl.logical = (is_alu || is_alui) && (f3 == 3'd4 || f3 == 3'd6 || f3 == 3'd7);
    e.ctrl.shifter = (is_alu || is_alui) && (f3 == 3'd1 || f3 == 3'd5);
    e.ctrl.load    = is_ld;
    e.ctrl.store   = is_st;
    e.ctrl.branch  = is_br || is_jal || is_jalr;
    // sub is funct3 0 with funct7 bit 5, sra shares that bit
    e.ctrl.adder_sub          = (is_alu && f3 == 3'd0 && w[30]) || is_br;
    e.ctrl.adder_imm_en       = is_jalr || is_alui;
    e.ctrl.adder_imm_val      = imm_i;
    e.ctrl.logical_mode       = f3[1:0];
    e.ctrl.shifter_arithmetic = w[30];
    e.ctrl.shifter_left       = !f3[2];
    e.ctrl.shifter_imm_en     = is_alui;
    e.ctrl.shifter_imm_val    = w[24:20];
    e.ctrl.branch_mode        = is_jal ? 3'd2 : (is_jalr ? 3'd3 : f3);
    e.ctrl.branch_pc          = ctx.pc + (is_jal ? imm_j : imm_b);
    e.rd_val = is_lui ? imm_u : (is_auipc ? ctx.pc + imm_u : ctx.pc + 32'd4);
    return e;
endfunction

`endif

//--- verification/tb_jfive_decode.sv
`timescale 1ns/10ps
`include "jfive_decode_macros.svh"

module tb_jfive_decode;

    localparam int RESET_CYCLES = 16;
    localparam int PRELOAD      = `JFIVE_THREADS * 31;
    localparam int NUM_RANDOM   = 300;
    localparam int NUM_STALL    = 4;
    localparam int MAX_CYCLES   = 4 * (NUM_RANDOM + NUM_STALL) + 200 + RESET_CYCLES
                                  + PRELOAD + NUM_STALL * 16;

    logic                                           clk;
    logic                                           reset;
    jfive_decode_pkg::instr_ctx_t                   s_ctx;
    logic                                           s_valid;
    logic                                           s_wait;
    jfive_decode_pkg::reg_write_t [`JFIVE_EXES-1:0] exe_wr;
    jfive_decode_pkg::wb_write_t                    wb;
    jfive_decode_pkg::instr_ctx_t                   m_ctx;
    jfive_decode_pkg::reg_write_t                   m_rd;
    logic                                           m_rs1_en;
    jfive_decode_pkg::rval_t                        m_rs1_val;
    logic                                           m_rs2_en;
    jfive_decode_pkg::rval_t                        m_rs2_val;
    jfive_decode_pkg::rval_t                        m_rd_val;
    jfive_decode_pkg::decode_ctrl_t                 m_ctrl;
    logic                                           m_valid;
    logic                                           m_wait;

    `include "decode_model.svh"

    expect_t     exp_q [$];
    expect_t     snapshot;
    expect_t     cur;
    expect_t     exp_e;
    logic        held;
    logic        random_wait;
    logic [31:0] rng;
    logic [31:0] wait_rng;
    int          cycles;
    int          error_count;

    jfive_decode u_jfive_decode (.*);

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic expect_t capture_outputs();
        expect_t c;
        c = '{ctx: m_ctx, rd: m_rd, rs1_en: m_rs1_en, rs1_val: m_rs1_val, rs2_en: m_rs2_en,
              rs2_val: m_rs2_val, ctrl: m_ctrl, rd_val: m_rd_val};
        return c;
    endfunction

    task automatic report_value(input string name, input logic [127:0] got,
                                input logic [127:0] want);
        error_count++;
        $display("[ERROR] %0t %s got %h expected %h", $time, name, got, want);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic report_text(input string what);
        error_count++;
        $display("[ERROR] %0t %s", $time, what);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    // random legal RV32I word of one of the nine classes
    task automatic random_ctx(output jfive_decode_pkg::instr_ctx_t ctx);
        logic [31:0] r;
        logic [31:0] hi;
        logic [2:0]  f3;
        logic [6:0]  f7;
        rng = xorshift(rng);
        r   = rng;
        rng = xorshift(rng);
        hi  = rng;
        rng = xorshift(rng);
        ctx.id = r[31:30];
        ctx.pc = {rng[31:2], 2'b00};
        f3     = r[17:15];
        f7     = (f3 == 3'd0 || f3 == 3'd5) ? {1'b0, hi[30], 5'd0} : 7'd0;
        case (r[29:20] % 9)
            0: ctx.instr = {hi[31:12], r[4:0], 7'b0110111};
            1: ctx.instr = {hi[31:12], r[4:0], 7'b0010111};
            2: ctx.instr = {hi[31:12], r[4:0], 7'b1101111};
            3: ctx.instr = {hi[31:20], r[9:5], 3'd0, r[4:0], 7'b1100111};
            4: ctx.instr = {hi[31:25], r[14:10], r[9:5], (f3 == 2 || f3 == 3) ? f3 + 3'd2 : f3,
                            hi[11:7], 7'b1100011};
            5: ctx.instr = {hi[31:20], r[9:5], (f3 == 3 || f3 > 5) ? {2'b00, f3[0]} : f3,
                            r[4:0], 7'b0000011};
            6: ctx.instr = {hi[31:25], r[14:10], r[9:5], f3 % 3'd3, hi[11:7], 7'b0100011};
            7: ctx.instr = {(f3 == 1 || f3 == 5) ? f7 : hi[31:25], hi[24:20], r[9:5], f3,
                            r[4:0], 7'b0010011};
            default: ctx.instr = {f7, r[14:10], r[9:5], f3, r[4:0], 7'b0110011};
        endcase
    endtask

    task automatic issue(input jfive_decode_pkg::instr_ctx_t ctx);
        @(negedge clk);
        s_ctx   = ctx;
        s_valid = 1'b1;
        do @(posedge clk); while (s_wait);
        exp_q.push_back(build_expect(ctx));
    endtask

    task automatic drain();
        @(negedge clk);
        s_valid = 1'b0;
        while (exp_q.size() != 0) @(posedge clk);
    endtask

    // ----------------------------------------------------------------------
    // source register held by an exe port and refreshed by wb
    // ----------------------------------------------------------------------
    task automatic stall_case();
        jfive_decode_pkg::instr_ctx_t ctx;
        int                           n;
        rng = xorshift(rng);
        ctx.id    = rng[1:0];
        ctx.pc    = {rng[31:4], 4'h0};
        ctx.instr = {7'd0, rng[14:10], 5'd1 + 5'(rng[9:5] % 31), 3'd0, rng[20:16], 7'b0110011};
        rng = xorshift(rng);
        regs[ctx.id][ctx.instr[19:15]] = rng;
        @(negedge clk);
        exe_wr[0] = '{en: 1'b1, id: ctx.id, idx: ctx.instr[19:15]};
        issue(ctx);
        @(negedge clk);
        s_valid = 1'b0;
        n = 0;
        while (!s_wait) begin
            @(posedge clk);
            n++;
            assert (n <= 8) else report_text("stall never raised s_wait");
        end
        repeat (3) begin
            @(posedge clk);
            assert (!m_valid && s_wait) else report_text("stalled instruction left stage 2");
        end
        @(negedge clk);
        wb = '{wr: '{en: 1'b1, id: ctx.id, idx: ctx.instr[19:15]}, val: rng};
        @(negedge clk);
        wb.wr.en  = 1'b0;
        exe_wr[0] = '0;
        // m_valid rises on the first edge after the port clears
        @(posedge clk);
        assert (!m_valid) else report_text("held instruction left before its exe port cleared");
        @(posedge clk);
        assert (m_valid) else report_text("held instruction not released after its port cleared");
        drain();
    endtask

    initial begin
        jfive_decode_pkg::instr_ctx_t ctx;
        clk         = 1'b0;
        reset       = 1'b1;
        s_ctx       = '0;
        s_valid     = 1'b0;
        exe_wr      = '0;
        wb          = '0;
        m_wait      = 1'b0;
        random_wait = 1'b0;
        rng         = 32'h5c86a8a7;
        wait_rng    = 32'h5c86a8a7 ^ 32'h1f2e3d4c;
        error_count = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // preload every register of every thread
        for (int t = 0; t < `JFIVE_THREADS; t++) begin
            for (int r = 1; r < 32; r++) begin
                rng = xorshift(rng);
                regs[t][r] = rng;
                wb = '{wr: '{en: 1'b1, id: 2'(t), idx: 5'(r)}, val: rng};
                @(negedge clk);
            end
        end
        wb.wr.en = 1'b0;

        random_wait = 1'b1;
        for (int i = 0; i < NUM_RANDOM; i++) begin
            random_ctx(ctx);
            issue(ctx);
        end
        drain();
        random_wait = 1'b0;

        for (int i = 0; i < NUM_STALL; i++) begin
            stall_case();
        end

        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    end

    always @(negedge clk) begin
        if (random_wait) begin
            wait_rng = xorshift(wait_rng);
            m_wait   = wait_rng[1:0] == 2'd0;
        end else begin
            m_wait = 1'b0;
        end
    end

    // ----------------------------------------------------------------------
    // scoreboard
    // ----------------------------------------------------------------------
    always @(posedge clk) begin
        if (reset) begin
            held = 1'b0;
        end else begin
            cur = capture_outputs();
            if (held) begin
                assert (m_valid) else report_text("m_valid dropped while m_wait was high");
                assert (cur === snapshot) else report_text("outputs changed while m_wait was high");
            end
            if (m_valid && !m_wait) begin
                assert (exp_q.size() != 0) else report_text("output with no instruction pending");
                exp_e = exp_q.pop_front();
                assert (cur.ctx === exp_e.ctx) else report_value("m_ctx", cur.ctx, exp_e.ctx);
                assert (cur.rd === exp_e.rd) else report_value("m_rd", cur.rd, exp_e.rd);
                assert (cur.rs1_en === exp_e.rs1_en)
                    else report_value("m_rs1_en", cur.rs1_en, exp_e.rs1_en);
                assert (cur.rs2_en === exp_e.rs2_en)
                    else report_value("m_rs2_en", cur.rs2_en, exp_e.rs2_en);
                assert (!exp_e.rs1_en || cur.rs1_val === exp_e.rs1_val)
                    else report_value("m_rs1_val", cur.rs1_val, exp_e.rs1_val);
                assert (!exp_e.rs2_en || cur.rs2_val === exp_e.rs2_val)
                    else report_value("m_rs2_val", cur.rs2_val, exp_e.rs2_val);
                assert (cur.ctrl === exp_e.ctrl) else report_value("m_ctrl", cur.ctrl, exp_e.ctrl);
                assert (cur.rd_val === exp_e.rd_val)
                    else report_value("m_rd_val", cur.rd_val, exp_e.rd_val);
            end
            held     = m_valid && m_wait;
            snapshot = cur;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("[ERROR] %0t run did not finish within %0d cycles", $time, MAX_CYCLES);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    end

    initial cycles = 0;

endmodule

//--- jfive_decode.f
+incdir+logic
logic/jfive_decode_pkg.sv
logic/reg_file.sv
logic/hazard_check.sv
logic/instr_classify.sv
logic/pipe_control.sv
logic/operand_fetch.sv
logic/control_decode.sv
logic/jfive_decode.sv
+incdir+verification
verification/tb_jfive_decode.sv

//--- Makefile
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f jfive_decode.f --top-module jfive_decode
	verilator --lint-only --timing --assert -f jfive_decode.f --top-module tb_jfive_decode

obj_dir/sim: jfive_decode.f logic/*.sv logic/*.svh verification/*.sv verification/*.svh
	verilator --binary --timing --assert -f jfive_decode.f --top-module tb_jfive_decode -o sim

sim: obj_dir/sim
	./obj_dir/sim

clean:
	rm -rf obj_dir
